// ==== verilog.f ====
+incdir+rtl
rtl/spi_mem_pkg.sv
rtl/input_conditioner.sv
rtl/spi_shift_register.sv
rtl/spi_slave_ctrl.sv
rtl/spi_data_memory.sv
rtl/spi_memory.sv
test/tb_clock_gen.sv
test/spi_memory_assertions.sv
test/spi_memory_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the SPI memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=spi_memory_tb
OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module "$TOP" -Mdir "$OBJ_DIR" -o "V$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ_DIR/V$TOP" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Done: no errors" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// ==== test/spi_memory_tb.sv ====
`include "spi_mem_defines.svh"

module spi_memory_tb;

    localparam int HALF_PERIOD    = 16;         // clk cycles per sclk phase
    localparam int ABORT_BITS     = 4;
    localparam int ACK_LIMIT      = 64;
    localparam int NUM_TXNS       = 17;
    localparam int TXN_CYCLES     = 2 * 8 * 2 * HALF_PERIOD + 3 * HALF_PERIOD + 2 * ACK_LIMIT;
    localparam int TIMEOUT_CYCLES = NUM_TXNS * TXN_CYCLES + 200;
    localparam logic [31:0] RAND_SEED = 32'h6cd8_8a20;

    typedef struct packed {
        logic                   is_read;
        logic                   abort;          // Raise cs after ABORT_BITS data bits
        logic                   from_shadow;    // Expected byte comes from the shadow
        spi_mem_pkg::spi_addr_t addr;
        spi_mem_pkg::spi_data_t wdata;
        spi_mem_pkg::spi_data_t expected;
    } txn_t;

    logic clk;
    logic rst;
    logic sclk_pin;
    logic cs_pin;
    logic mosi_pin;
    logic miso;
    logic miso_oe;

    txn_t                   txn_table [NUM_TXNS];
    spi_mem_pkg::spi_data_t shadow [`SPI_MEM_DEPTH];
    logic                   ack_seen;
    int                     errors = 0;
    int                     checks = 0;
    int                     assert_fails;
    int                     cycle_cnt = 0;

    tb_clock_gen #(.PERIOD(8), .RESET_CYCLES(10)) clock_i (.clk(clk), .rst(rst));

    spi_memory dut_i (
        .clk(clk), .rst(rst),
        .sclk_pin(sclk_pin), .cs_pin(cs_pin), .mosi_pin(mosi_pin),
        .miso(miso), .miso_oe(miso_oe)
    );

    bind spi_slave_ctrl spi_memory_assertions assertions_i (
        .clk(clk), .rst(rst), .wb_req(wb_req), .wb_rsp(wb_rsp),
        .miso_oe(miso_oe), .cs_level(cs_level)
    );

    // --------------------------------------------------------------------------
    // Helpers
    // --------------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, actual, expected,
                     $time);
        end
    endtask

    function automatic txn_t make_txn(input logic is_read, input logic abort,
                                      input logic from_shadow,
                                      input spi_mem_pkg::spi_addr_t addr,
                                      input spi_mem_pkg::spi_data_t wdata,
                                      input spi_mem_pkg::spi_data_t expected);
        txn_t t;
        t.is_read     = is_read;
        t.abort       = abort;
        t.from_shadow = from_shadow;
        t.addr        = addr;
        t.wdata       = wdata;
        t.expected    = expected;
        return t;
    endfunction

    // One sclk phase, noting any Wishbone ack on the way
    task automatic half_period();
        repeat (HALF_PERIOD) begin
            @(negedge clk);
            if (dut_i.wb_rsp.ack) begin
                ack_seen = 1'b1;
            end
        end
    endtask

    task automatic wait_ack(input string what, input spi_mem_pkg::spi_addr_t addr);
        int waited;
        waited = 0;
        while (!ack_seen && waited < ACK_LIMIT) begin
            @(negedge clk);
            if (dut_i.wb_rsp.ack) begin
                ack_seen = 1'b1;
            end
            waited++;
        end
        if (!ack_seen) begin
            errors++;
            $display("Error: no Wishbone ack for the %s of address 0x%0h", what, addr);
        end
    endtask

    // Mode 0 bit-banging, MSB first
    task automatic transfer_byte(input spi_mem_pkg::spi_data_t tx, input int n_bits,
                                 input logic expect_oe, output spi_mem_pkg::spi_data_t rx);
        rx = '0;
        for (int i = 7; i > 7 - n_bits; i--) begin
            mosi_pin = tx[i];
            half_period();
            rx = {rx[6:0], miso};                       // Sampled as sclk rises
            if (expect_oe) begin
                check_value("miso_oe", 32'(miso_oe), 32'd1);
            end
            sclk_pin = 1'b1;
            half_period();
            sclk_pin = 1'b0;
        end
    endtask

    task automatic run_txn(input txn_t t);
        spi_mem_pkg::spi_data_t rx;
        spi_mem_pkg::spi_data_t expected_byte;
        ack_seen = 1'b0;
        cs_pin   = 1'b0;
        transfer_byte({t.addr, t.is_read}, 8, 1'b0, rx);
        if (t.is_read) begin
            wait_ack("read", t.addr);
            transfer_byte(8'h00, 8, 1'b1, rx);
            expected_byte = t.from_shadow ? shadow[t.addr] : t.expected;
            check_value($sformatf("miso byte @0x%0h", t.addr), 32'(rx), 32'(expected_byte));
            half_period();
        end else if (t.abort) begin
            transfer_byte(t.wdata, ABORT_BITS, 1'b0, rx);
            half_period();
        end else begin
            transfer_byte(t.wdata, 8, 1'b0, rx);
            half_period();
            wait_ack("write", t.addr);
            shadow[t.addr] = t.wdata;                   // Completed writes only
        end
        cs_pin = 1'b1;
        half_period();
        half_period();
        check_value("miso_oe", 32'(miso_oe), 32'd0);
        if (t.abort && ack_seen) begin
            errors++;
            $display("Error: aborted write to address 0x%0h reached the memory", t.addr);
        end
    endtask

    task automatic fill_table();
        txn_table[0]  = make_txn(1'b1, 1'b0, 1'b0, 7'h05, 8'h00, 8'h00);     // Never written
        txn_table[1]  = make_txn(1'b0, 1'b0, 1'b0, 7'h12, 8'ha5, 8'h00);
        txn_table[2]  = make_txn(1'b1, 1'b0, 1'b0, 7'h12, 8'h00, 8'ha5);
        txn_table[3]  = make_txn(1'b0, 1'b0, 1'b0, 7'h12, 8'h3c, 8'h00);     // Overwrite
        txn_table[4]  = make_txn(1'b1, 1'b0, 1'b0, 7'h12, 8'h00, 8'h3c);
        txn_table[5]  = make_txn(1'b0, 1'b0, 1'b0, 7'h40, 8'h77, 8'h00);
        txn_table[6]  = make_txn(1'b0, 1'b1, 1'b0, 7'h40, 8'he1, 8'h00);     // Aborted
        txn_table[7]  = make_txn(1'b1, 1'b0, 1'b0, 7'h40, 8'h00, 8'h77);
        txn_table[8]  = make_txn(1'b0, 1'b0, 1'b0, 7'h7f, 8'($urandom), 8'h00);
        txn_table[9]  = make_txn(1'b0, 1'b0, 1'b0, 7'h01, 8'h5a, 8'h00);
        txn_table[10] = make_txn(1'b0, 1'b0, 1'b0, 7'h33, 8'($urandom), 8'h00);
        txn_table[11] = make_txn(1'b1, 1'b0, 1'b1, 7'h7f, 8'h00, 8'h00);
        txn_table[12] = make_txn(1'b0, 1'b0, 1'b0, 7'h00, 8'($urandom), 8'h00);
        txn_table[13] = make_txn(1'b1, 1'b0, 1'b0, 7'h01, 8'h00, 8'h5a);
        txn_table[14] = make_txn(1'b1, 1'b0, 1'b1, 7'h33, 8'h00, 8'h00);
        txn_table[15] = make_txn(1'b1, 1'b0, 1'b1, 7'h00, 8'h00, 8'h00);
        txn_table[16] = make_txn(1'b1, 1'b0, 1'b0, 7'h7e, 8'h00, 8'h00);
    endtask

    // --------------------------------------------------------------------------
    // Run limit
    // --------------------------------------------------------------------------
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run went past %0d clock cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        sclk_pin = 1'b0;
        cs_pin   = 1'b1;
        mosi_pin = 1'b0;
        ack_seen = 1'b0;
        void'($urandom(RAND_SEED));
        for (int i = 0; i < `SPI_MEM_DEPTH; i++) begin
            shadow[i] = '0;                             // Memory clears on reset
        end
        fill_table();

        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        check_value("miso_oe", 32'(miso_oe), 32'd0);

        for (int i = 0; i < NUM_TXNS; i++) begin
            run_txn(txn_table[i]);
        end

        assert_fails = int'(dut_i.ctrl.assertions_i.fail_count);
        $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                 assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== test/spi_memory_assertions.sv ====
module spi_memory_assertions (
    input logic                 clk,
    input logic                 rst,
    input spi_mem_pkg::wb_req_t wb_req,
    input spi_mem_pkg::wb_rsp_t wb_rsp,
    input logic                 miso_oe,
    input logic                 cs_level
);

    int unsigned fail_count = 0;    // Read back by the testbench at the end

    // --------------------------------------------------------------------------
    // Wishbone classic master rules
    // --------------------------------------------------------------------------
    stb_needs_cyc: assert property (@(posedge clk) disable iff (rst)
        wb_req.stb |-> wb_req.cyc)
        else begin
            $error("Wishbone stb high without cyc");
            fail_count++;
        end

    // Whole request held until the slave answers
    req_held_until_ack: assert property (@(posedge clk) disable iff (rst)
        (wb_req.stb && !wb_rsp.ack) |=> (wb_req.stb && $stable(wb_req)))
        else begin
            $error("Wishbone request changed before ack");
            fail_count++;
        end

    // Pad enable only inside a selected read, once its data is back
    oe_needs_cs: assert property (@(posedge clk) disable iff (rst)
        miso_oe |-> !cs_level && ($past(miso_oe) || $past(wb_rsp.ack && !wb_req.we)))
        else begin
            $error("miso_oe high outside a selected read data byte");
            fail_count++;
        end

endmodule

// ==== test/tb_clock_gen.sv ====
module tb_clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset released away from the rising edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== rtl/spi_memory.sv ====
module spi_memory (
    input  logic clk,
    input  logic rst,
    input  logic sclk_pin,
    input  logic cs_pin,
    input  logic mosi_pin,
    output logic miso,
    output logic miso_oe     // Enable for an outer pad buffer
);

    logic                   sclk_rise;
    logic                   sclk_fall;
    logic                   cs_level;
    logic                   mosi_level;
    logic                   sr_load;
    logic                   sr_serial;
    spi_mem_pkg::spi_data_t sr_data;
    spi_mem_pkg::spi_data_t sr_load_data;
    spi_mem_pkg::wb_req_t   wb_req;
    spi_mem_pkg::wb_rsp_t   wb_rsp;

    // --------------------------------------------------------------------------
    // Pin conditioning
    // --------------------------------------------------------------------------
    input_conditioner sclk_ic (
        .clk(clk), .rst(rst), .pin(sclk_pin),
        .level(), .rise(sclk_rise), .fall(sclk_fall)
    );

    input_conditioner #(.RESET_LEVEL(1'b1)) cs_ic (     // cs idles high
        .clk(clk), .rst(rst), .pin(cs_pin),
        .level(cs_level), .rise(), .fall()
    );

    input_conditioner mosi_ic (
        .clk(clk), .rst(rst), .pin(mosi_pin),
        .level(mosi_level), .rise(), .fall()
    );

    spi_shift_register shift_reg (
        .clk(clk), .rst(rst),
        .shift(sclk_rise), .serial_in(mosi_level),
        .load(sr_load), .load_data(sr_load_data),
        .parallel_out(sr_data), .serial_out(sr_serial)
    );

    spi_slave_ctrl ctrl (
        .clk(clk), .rst(rst),
        .sclk_rise(sclk_rise), .sclk_fall(sclk_fall), .cs_level(cs_level),
        .sr_data(sr_data), .sr_load(sr_load), .sr_load_data(sr_load_data),
        .sr_serial(sr_serial), .miso(miso), .miso_oe(miso_oe),
        .wb_req(wb_req), .wb_rsp(wb_rsp)
    );

    spi_data_memory memory (
        .clk(clk), .rst(rst), .wb_req(wb_req), .wb_rsp(wb_rsp)
    );

endmodule

// ==== rtl/spi_data_memory.sv ====
`include "spi_mem_defines.svh"

module spi_data_memory (
    input  logic                 clk,
    input  logic                 rst,
    input  spi_mem_pkg::wb_req_t wb_req,
    output spi_mem_pkg::wb_rsp_t wb_rsp
);

    spi_mem_pkg::spi_data_t mem [`SPI_MEM_DEPTH];
    spi_mem_pkg::spi_data_t rd_data;
    logic                   ack;
    logic                   access;

    // New access only when no ack is outstanding
    assign access = wb_req.cyc && wb_req.stb && !ack;

    // --------------------------------------------------------------------------
    // Storage with registered ack and read data
    // --------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ack     <= 1'b0;
            rd_data <= '0;
            for (int i = 0; i < `SPI_MEM_DEPTH; i++) begin
                mem[i] <= '0;                           // Start from a blank array
            end
        end else begin
            ack <= access;                              // One cycle pulse
            if (access && wb_req.we) begin
                mem[wb_req.adr] <= wb_req.dat;
            end
            if (access) begin
                rd_data <= mem[wb_req.adr];             // Valid with ack
            end
        end
    end

    assign wb_rsp.ack = ack;
    assign wb_rsp.dat = rd_data;

endmodule

// ==== rtl/spi_slave_ctrl.sv ====
module spi_slave_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   sclk_rise,
    input  logic                   sclk_fall,
    input  logic                   cs_level,
    input  spi_mem_pkg::spi_data_t sr_data,
    output logic                   sr_load,
    output spi_mem_pkg::spi_data_t sr_load_data,
    input  logic                   sr_serial,
    output logic                   miso,
    output logic                   miso_oe,
    output spi_mem_pkg::wb_req_t   wb_req,
    input  spi_mem_pkg::wb_rsp_t   wb_rsp
);

    spi_mem_pkg::spi_state_t state;
    logic [3:0]              bit_cnt;   // Counts sclk rises, 0 to 8
    logic                    byte_done;
    logic                    counting;

    assign counting  = (state == spi_mem_pkg::GET_CMD) ||
                       (state == spi_mem_pkg::GET_DATA) ||
                       (state == spi_mem_pkg::SEND_DATA);
    assign byte_done = (bit_cnt == 4'd8);

    // --------------------------------------------------------------------------
    // Transaction FSM and Wishbone master
    // --------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= spi_mem_pkg::IDLE;
            bit_cnt <= '0;
            wb_req  <= '0;
        end else begin
            if (counting && sclk_rise && !byte_done) begin
                bit_cnt <= bit_cnt + 1'b1;
            end

            case (state)
                spi_mem_pkg::IDLE: begin
                    bit_cnt <= '0;
                    if (!cs_level) begin
                        state <= spi_mem_pkg::GET_CMD;
                    end
                end

                spi_mem_pkg::GET_CMD: begin
                    if (cs_level) begin
                        state <= spi_mem_pkg::IDLE;             // Abort
                    end else if (byte_done) begin
                        bit_cnt    <= '0;
                        wb_req.adr <= spi_mem_pkg::spi_addr_t'(sr_data >> 1);
                        if (sr_data[0]) begin                   // Read command
                            wb_req.cyc <= 1'b1;
                            wb_req.stb <= 1'b1;
                            wb_req.we  <= 1'b0;
                            state      <= spi_mem_pkg::WB_READ;
                        end else begin
                            state <= spi_mem_pkg::GET_DATA;
                        end
                    end
                end

                // Hold the request until the slave answers
                spi_mem_pkg::WB_READ: begin
                    if (wb_rsp.ack) begin
                        wb_req.cyc <= 1'b0;
                        wb_req.stb <= 1'b0;
                        state      <= spi_mem_pkg::SEND_DATA;
                    end
                end

                spi_mem_pkg::SEND_DATA: begin
                    if (cs_level) begin
                        state <= spi_mem_pkg::IDLE;
                    end else if (byte_done) begin
                        state <= spi_mem_pkg::DONE;
                    end
                end

                spi_mem_pkg::GET_DATA: begin
                    if (cs_level) begin
                        state <= spi_mem_pkg::IDLE;             // Partial byte dropped
                    end else if (byte_done) begin
                        wb_req.dat <= sr_data;
                        wb_req.we  <= 1'b1;
                        wb_req.cyc <= 1'b1;
                        wb_req.stb <= 1'b1;
                        state      <= spi_mem_pkg::WB_WRITE;
                    end
                end

                spi_mem_pkg::WB_WRITE: begin
                    if (wb_rsp.ack) begin
                        wb_req.cyc <= 1'b0;
                        wb_req.stb <= 1'b0;
                        wb_req.we  <= 1'b0;
                        state      <= spi_mem_pkg::DONE;
                    end
                end

                spi_mem_pkg::DONE: begin
                    if (cs_level) begin
                        state <= spi_mem_pkg::IDLE;
                    end
                end

                default: state <= spi_mem_pkg::IDLE;
            endcase
        end
    end

    // Read byte goes into the shift register in the ack cycle
    assign sr_load      = (state == spi_mem_pkg::WB_READ) && wb_rsp.ack;
    assign sr_load_data = wb_rsp.dat;

    // --------------------------------------------------------------------------
    // MISO, updated on sclk fall so the master samples a settled bit
    // --------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            miso <= 1'b0;
        end else if (sclk_fall) begin
            miso <= sr_serial;
        end
    end

    assign miso_oe = (state == spi_mem_pkg::SEND_DATA) && !cs_level;

endmodule

// ==== rtl/spi_shift_register.sv ====
module spi_shift_register (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   shift,
    input  logic                   serial_in,
    input  logic                   load,
    input  spi_mem_pkg::spi_data_t load_data,
    output spi_mem_pkg::spi_data_t parallel_out,
    output logic                   serial_out
);

    spi_mem_pkg::spi_data_t data_q;

    // --------------------------------------------------------------------------
    // Load wins over shift
    // --------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            data_q <= '0;
        end else if (load) begin
            data_q <= load_data;
        end else if (shift) begin
            data_q <= {data_q[$bits(data_q)-2:0], serial_in};   // MSB first
        end
    end

    assign parallel_out = data_q;
    assign serial_out   = data_q[$bits(data_q)-1];              // Top bit goes out next

endmodule

// ==== rtl/input_conditioner.sv ====
`include "spi_mem_defines.svh"

module input_conditioner #(
    parameter logic RESET_LEVEL = 1'b0  // Idle level of the pin
) (
    input  logic clk,
    input  logic rst,
    input  logic pin,
    output logic level,
    output logic rise,
    output logic fall
);

    localparam int CNT_W = $clog2(`SPI_MEM_FILTER_WAIT + 1);

    logic             sync_0;
    logic             sync_1;
    logic             level_d;
    logic [CNT_W-1:0] stable_cnt;

    // Two-flop synchronizer
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_0 <= RESET_LEVEL;
            sync_1 <= RESET_LEVEL;
        end else begin
            sync_0 <= pin;
            sync_1 <= sync_0;
        end
    end

    // Glitch filter, new level must hold for the full wait
    always_ff @(posedge clk) begin
        if (rst) begin
            level      <= RESET_LEVEL;
            stable_cnt <= '0;
        end else if (sync_1 == level) begin
            stable_cnt <= '0;                           // Bounced back, start over
        end else if (stable_cnt == CNT_W'(`SPI_MEM_FILTER_WAIT - 1)) begin
            level      <= sync_1;
            stable_cnt <= '0;
        end else begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            level_d <= RESET_LEVEL;
        end else begin
            level_d <= level;
        end
    end

    assign rise = level & ~level_d;                     // Same cycle as level change
    assign fall = ~level & level_d;

endmodule

// ==== rtl/spi_mem_pkg.sv ====
`include "spi_mem_defines.svh"

package spi_mem_pkg;

    typedef logic [`SPI_MEM_ADDR_W-1:0] spi_addr_t;   // Memory address
    typedef logic [`SPI_MEM_DATA_W-1:0] spi_data_t;   // One data byte

    // Wishbone master to slave
    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        spi_addr_t adr;
        spi_data_t dat;     // Write data
    } wb_req_t;

    // Wishbone slave to master
    typedef struct packed {
        logic      ack;
        spi_data_t dat;     // Read data, valid with ack
    } wb_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        GET_CMD,
        WB_READ,
        SEND_DATA,
        GET_DATA,
        WB_WRITE,
        DONE
    } spi_state_t;

endpackage

// ==== rtl/spi_mem_defines.svh ====
`ifndef SPI_MEM_DEFINES_SVH
`define SPI_MEM_DEFINES_SVH

// --------------------------------------------------------------------------
// SPI byte memory sizing
// --------------------------------------------------------------------------

// Address comes from the upper seven bits of the command byte
`define SPI_MEM_ADDR_W 7

// One data byte per location
`define SPI_MEM_DATA_W 8

// Full range of a 7-bit address
`define SPI_MEM_DEPTH 128

// Cycles a synchronized pin level must hold before it is accepted
`define SPI_MEM_FILTER_WAIT 2

`endif
